/* dv/decode_issue_cases.txt */
// Columns: pc _ instruction _ expected wdata _ seq _ rd _ pipe (00 alu, 01 mul)
// One case per line in issue order; registers start at zero
// Immediate forms
00000100_00500093_00000005_00_01_00
00000104_ffd00113_fffffffd_01_02_00
00000108_123451b7_12345000_02_03_00
0000010c_00001217_0000110c_03_04_00
00000110_0f01e293_123450f0_04_05_00
00000114_7f017313_000007f0_05_06_00
00000118_fff0c393_fffffffa_06_07_00
// Register-register forms
0000011c_00208433_00000002_07_08_00
00000120_402084b3_00000008_08_09_00
00000124_0072f533_123450f0_09_0a_00
00000128_0060e5b3_000007f5_0a_0b_00
0000012c_0041c633_1234410c_0b_0c_00
00000130_001126b3_00000001_0c_0d_00
// Multiply chain, mul feeding add feeding mul
00000134_02310733_c9631000_0d_0e_01
00000138_001707b3_c9631005_0e_0f_00
0000013c_02f78833_3edea019_0f_10_01
// Write to x0, then reads of x0
00000140_00108033_0000000a_10_00_00
00000144_00700893_00000007_11_11_00
00000148_01000933_3edea019_12_12_00
0000014c_411009b3_fffffff9_13_13_00

/* decode_issue_top.f */
rtl/isa_pkg.sv
rtl/issue_pkg.sv
rtl/inst_decoder.sv
rtl/regfile_pending.sv
rtl/inst_router.sv
rtl/decode_issue_unit.sv
rtl/alu_pipe.sv
rtl/mul_pipe.sv
rtl/decode_issue_top.sv
dv/decode_issue_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode-issue testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter project root"
  exit 1
fi

verilator --binary --timing --assert --top-module decode_issue_tb -f decode_issue_top.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/Vdecode_issue_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^TESTS PASSED$"; then
  exit 0
fi
exit 1

/* dv/decode_issue_tb.sv */
// ----------------------------------------------------------
// Decode-issue subsystem testbench
// Replays the cases file through fetch with random gaps and
// checks both completion ports in sequence order
// ----------------------------------------------------------
`timescale 1ns/10ps

module decode_issue_tb import issue_pkg::*; ();

  // DUT ports
  logic                     clk;
  logic                     rst;
  logic                     inst_val;
  logic [31:0]              inst;
  logic [31:0]              pc;
  logic [SEQ_BITS-1:0]      seq_num;
  logic                     inst_rdy;
  logic                     alu_cmp_val;
  logic [REG_ADDR_BITS-1:0] alu_cmp_waddr;
  logic [31:0]              alu_cmp_wdata;
  logic [SEQ_BITS-1:0]      alu_cmp_seq_num;
  logic                     mul_cmp_val;
  logic [REG_ADDR_BITS-1:0] mul_cmp_waddr;
  logic [31:0]              mul_cmp_wdata;
  logic [SEQ_BITS-1:0]      mul_cmp_seq_num;

  // Raw file image, then stimulus and expected tables
  logic [119:0] case_mem  [64];
  logic [31:0]  stim_pc   [64];
  logic [31:0]  stim_inst [64];
  logic [7:0]   exp_seq   [64];
  logic [7:0]   exp_reg   [64];
  logic [31:0]  exp_val   [64];
  logic [7:0]   exp_pipe  [64];

  // Scoreboard state
  int          num_cases;
  int          n_accepted;
  int          n_done;
  int          value_errors;
  int          other_errors;
  bit          timed_out;
  logic [31:0] lfsr;

  decode_issue_top decode_issue_i (
    .clk             (clk),
    .rst             (rst),
    .inst_val        (inst_val),
    .inst            (inst),
    .pc              (pc),
    .seq_num         (seq_num),
    .inst_rdy        (inst_rdy),
    .alu_cmp_val     (alu_cmp_val),
    .alu_cmp_waddr   (alu_cmp_waddr),
    .alu_cmp_wdata   (alu_cmp_wdata),
    .alu_cmp_seq_num (alu_cmp_seq_num),
    .mul_cmp_val     (mul_cmp_val),
    .mul_cmp_waddr   (mul_cmp_waddr),
    .mul_cmp_wdata   (mul_cmp_wdata),
    .mul_cmp_seq_num (mul_cmp_seq_num)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 32'h80200003;
    return n;
  endfunction

  // One LFSR step per bit taken
  task automatic random_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Split file lines into the two tables, zero word ends the list
  task automatic load_cases();
    for (int i = 0; i < 64; i++)
      case_mem[i] = '0;
    $readmemh("dv/decode_issue_cases.txt", case_mem);
    num_cases = 0;
    for (int i = 0; i < 64; i++) begin
      if (case_mem[i][87:56] != '0) begin
        stim_pc[num_cases]   = case_mem[i][119:88];
        stim_inst[num_cases] = case_mem[i][87:56];
        exp_val[num_cases]   = case_mem[i][55:24];
        exp_seq[num_cases]   = case_mem[i][23:16];
        exp_reg[num_cases]   = case_mem[i][15:8];
        exp_pipe[num_cases]  = case_mem[i][7:0];
        num_cases++;
      end
    end
  endtask

  // Five reset cycles, then idle state check
  task automatic reset_dut();
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    if (inst_rdy !== 1'b1) begin
      $display("[FAIL] reset_state inst_rdy: expected 1, actual %b", inst_rdy);
      value_errors++;
    end
    if (alu_cmp_val !== 1'b0) begin
      $display("[FAIL] reset_state alu_cmp_val: expected 0, actual %b", alu_cmp_val);
      value_errors++;
    end
    if (mul_cmp_val !== 1'b0) begin
      $display("[FAIL] reset_state mul_cmp_val: expected 0, actual %b", mul_cmp_val);
      value_errors++;
    end
    @(posedge clk);
    #1;
  endtask

  // Hold the offer until the fetch handshake takes it
  task automatic offer_case(input int idx);
    int   waited;
    logic took;
    inst_val = 1'b1;
    inst     = stim_inst[idx];
    pc       = stim_pc[idx];
    seq_num  = SEQ_BITS'(idx);
    waited   = 0;
    took     = 1'b0;
    while (!took && !timed_out) begin
      // inst_rdy is settled by mid-cycle
      @(negedge clk);
      took = inst_rdy;
      @(posedge clk);
      #1;
      if (took) begin
        n_accepted++;
      end else begin
        waited++;
        if (waited > 200) begin
          $display("Timeout: case %0d was never accepted by the fetch handshake", idx);
          other_errors++;
          timed_out = 1'b1;
        end
      end
    end
    inst_val = 1'b0;
  endtask

  // Compare one completion with the next expected entry
  task automatic check_completion(input int pipe_id, input logic [7:0] seq,
                                  input logic [4:0] waddr, input logic [31:0] data);
    string name;
    if (n_done >= n_accepted) begin
      $display("Completion with seq %0d arrived while no instruction was outstanding", seq);
      other_errors++;
    end else begin
      name = $sformatf("case_%0d", n_done);
      if (seq !== exp_seq[n_done]) begin
        $display("[FAIL] %s seq_num: expected %0d, actual %0d", name, exp_seq[n_done], seq);
        value_errors++;
      end
      if ({3'b0, waddr} !== exp_reg[n_done]) begin
        $display("[FAIL] %s waddr: expected %0d, actual %0d", name, exp_reg[n_done], waddr);
        value_errors++;
      end
      if (data !== exp_val[n_done]) begin
        $display("[FAIL] %s wdata: expected %h, actual %h", name, exp_val[n_done], data);
        value_errors++;
      end
      if (pipe_id != int'(exp_pipe[n_done])) begin
        $display("[FAIL] %s pipe: expected %0d, actual %0d", name, exp_pipe[n_done], pipe_id);
        value_errors++;
      end
      n_done++;
    end
  endtask

  // Wait for every completion, then a few quiet cycles
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (n_done < num_cases && !timed_out) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 200) begin
        $display("Timeout: only %0d of %0d completions arrived", n_done, num_cases);
        other_errors++;
        timed_out = 1'b1;
      end
    end
    // Catch stray completions past the last one
    repeat (8) @(posedge clk);
  endtask

  // ----------------------------------------------------------
  // Completion monitor
  // ----------------------------------------------------------

  always @(negedge clk) begin
    if (rst === 1'b0) begin
      // Equal latency, so never two at once
      if (alu_cmp_val && mul_cmp_val) begin
        $display("Both completion ports were valid in the same cycle");
        other_errors++;
      end
      if (alu_cmp_val)
        check_completion(PIPE_ALU, alu_cmp_seq_num, alu_cmp_waddr, alu_cmp_wdata);
      if (mul_cmp_val)
        check_completion(PIPE_MUL, mul_cmp_seq_num, mul_cmp_waddr, mul_cmp_wdata);
    end
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    int gap;
    rst          = 1'b1;
    inst_val     = 1'b0;
    inst         = '0;
    pc           = '0;
    seq_num      = '0;
    lfsr         = 32'hcaed5a42;
    n_accepted   = 0;
    n_done       = 0;
    value_errors = 0;
    other_errors = 0;
    timed_out    = 1'b0;
    load_cases();
    if (num_cases == 0) begin
      $display("No cases were loaded from the cases file");
      other_errors++;
    end
    reset_dut();
    for (int i = 0; i < num_cases; i++) begin
      if (!timed_out) begin
        // 0 to 3 idle cycles before each offer
        random_bits(2, gap);
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
        offer_case(i);
      end
    end
    if (!timed_out)
      wait_drain();
    $display("Errors: %0d value, %0d other; %0d of %0d completions checked",
             value_errors, other_errors, n_done, num_cases);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* rtl/decode_issue_top.sv */
// ----------------------------------------------------------
// Decode-issue subsystem top
// Decode-issue unit with ALU and multiply pipes
// ----------------------------------------------------------
`timescale 1ns/10ps

module decode_issue_top import isa_pkg::*; import issue_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     inst_val,
  input  logic [31:0]              inst,
  input  logic [31:0]              pc,
  input  logic [SEQ_BITS-1:0]      seq_num,
  output logic                     inst_rdy,
  output logic                     alu_cmp_val,
  output logic [REG_ADDR_BITS-1:0] alu_cmp_waddr,
  output logic [31:0]              alu_cmp_wdata,
  output logic [SEQ_BITS-1:0]      alu_cmp_seq_num,
  output logic                     mul_cmp_val,
  output logic [REG_ADDR_BITS-1:0] mul_cmp_waddr,
  output logic [31:0]              mul_cmp_wdata,
  output logic [SEQ_BITS-1:0]      mul_cmp_seq_num
);

  // Issue bus shared by both pipes
  logic [NUM_PIPES-1:0]     issue_val;
  uop_e                     uop;
  logic [31:0]              op1;
  logic [31:0]              op2;
  logic [31:0]              issue_pc;
  logic [REG_ADDR_BITS-1:0] issue_waddr;
  logic                     issue_wen;
  logic [SEQ_BITS-1:0]      issue_seq_num;
  // Write enables only feed write-back
  logic                     alu_cmp_wen;
  logic                     mul_cmp_wen;

  decode_issue_unit unit_i (
    .clk           (clk),
    .rst           (rst),
    .inst_val      (inst_val),
    .inst          (inst),
    .pc            (pc),
    .seq_num       (seq_num),
    .inst_rdy      (inst_rdy),
    .issue_val     (issue_val),
    .uop           (uop),
    .op1           (op1),
    .op2           (op2),
    .issue_pc      (issue_pc),
    .issue_waddr   (issue_waddr),
    .issue_wen     (issue_wen),
    .issue_seq_num (issue_seq_num),
    .alu_cmp_val   (alu_cmp_val),
    .alu_cmp_wen   (alu_cmp_wen),
    .alu_cmp_waddr (alu_cmp_waddr),
    .alu_cmp_wdata (alu_cmp_wdata),
    .mul_cmp_val   (mul_cmp_val),
    .mul_cmp_wen   (mul_cmp_wen),
    .mul_cmp_waddr (mul_cmp_waddr),
    .mul_cmp_wdata (mul_cmp_wdata)
  );

  alu_pipe alu_i (
    .clk         (clk),
    .rst         (rst),
    .issue_val   (issue_val[PIPE_ALU]),
    .uop         (uop),
    .op1         (op1),
    .op2         (op2),
    .pc          (issue_pc),
    .waddr       (issue_waddr),
    .wen         (issue_wen),
    .seq_num     (issue_seq_num),
    .cmp_val     (alu_cmp_val),
    .cmp_waddr   (alu_cmp_waddr),
    .cmp_wdata   (alu_cmp_wdata),
    .cmp_wen     (alu_cmp_wen),
    .cmp_seq_num (alu_cmp_seq_num)
  );

  mul_pipe mul_i (
    .clk         (clk),
    .rst         (rst),
    .issue_val   (issue_val[PIPE_MUL]),
    .op1         (op1),
    .op2         (op2),
    .waddr       (issue_waddr),
    .wen         (issue_wen),
    .seq_num     (issue_seq_num),
    .cmp_val     (mul_cmp_val),
    .cmp_waddr   (mul_cmp_waddr),
    .cmp_wdata   (mul_cmp_wdata),
    .cmp_wen     (mul_cmp_wen),
    .cmp_seq_num (mul_cmp_seq_num)
  );

endmodule

/* rtl/mul_pipe.sv */
// ----------------------------------------------------------
// Multiply pipe
// Two-stage 32 x 32 multiply returning the low word
// ----------------------------------------------------------
`timescale 1ns/10ps

module mul_pipe import issue_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     issue_val,
  input  logic [31:0]              op1,
  input  logic [31:0]              op2,
  input  logic [REG_ADDR_BITS-1:0] waddr,
  input  logic                     wen,
  input  logic [SEQ_BITS-1:0]      seq_num,
  output logic                     cmp_val,
  output logic [REG_ADDR_BITS-1:0] cmp_waddr,
  output logic [31:0]              cmp_wdata,
  output logic                     cmp_wen,
  output logic [SEQ_BITS-1:0]      cmp_seq_num
);

  // Partial products of the 16-bit halves
  logic                     s1_val;
  logic [31:0]              s1_ll;
  logic [15:0]              s1_lh;
  logic [15:0]              s1_hl;
  logic [REG_ADDR_BITS-1:0] s1_waddr;
  logic                     s1_wen;
  logic [SEQ_BITS-1:0]      s1_seq;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val  <= 1'b0;
      cmp_val <= 1'b0;
    end else begin
      s1_val  <= issue_val;
      cmp_val <= s1_val;
    end
  end

  // Stage one, low word products only
  // Signed and unsigned products agree in the low 32 bits
  always_ff @(posedge clk) begin
    if (issue_val) begin
      s1_ll    <= {16'b0, op1[15:0]} * {16'b0, op2[15:0]};
      s1_lh    <= op1[15:0] * op2[31:16];
      s1_hl    <= op1[31:16] * op2[15:0];
      s1_waddr <= waddr;
      s1_wen   <= wen;
      s1_seq   <= seq_num;
    end
  end

  // Stage two, cross terms shifted into the upper half
  always_ff @(posedge clk) begin
    if (s1_val) begin
      cmp_wdata   <= s1_ll + {s1_lh + s1_hl, 16'b0};
      cmp_waddr   <= s1_waddr;
      cmp_wen     <= s1_wen;
      cmp_seq_num <= s1_seq;
    end
  end

endmodule

/* rtl/alu_pipe.sv */
// ----------------------------------------------------------
// ALU pipe
// Two stages: compute at issue, then register completion
// ----------------------------------------------------------
`timescale 1ns/10ps

module alu_pipe import isa_pkg::*; import issue_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     issue_val,
  input  uop_e                     uop,
  input  logic [31:0]              op1,
  input  logic [31:0]              op2,
  input  logic [31:0]              pc,
  input  logic [REG_ADDR_BITS-1:0] waddr,
  input  logic                     wen,
  input  logic [SEQ_BITS-1:0]      seq_num,
  output logic                     cmp_val,
  output logic [REG_ADDR_BITS-1:0] cmp_waddr,
  output logic [31:0]              cmp_wdata,
  output logic                     cmp_wen,
  output logic [SEQ_BITS-1:0]      cmp_seq_num
);

  logic [31:0]              result;
  logic                     s1_val;
  logic [31:0]              s1_result;
  logic [REG_ADDR_BITS-1:0] s1_waddr;
  logic                     s1_wen;
  logic [SEQ_BITS-1:0]      s1_seq;

  always_comb begin
    case (uop)
      UOP_ADD, UOP_ADDI: result = op1 + op2;
      UOP_SUB:           result = op1 - op2;
      UOP_AND, UOP_ANDI: result = op1 & op2;
      UOP_OR,  UOP_ORI:  result = op1 | op2;
      UOP_XOR, UOP_XORI: result = op1 ^ op2;
      UOP_SLT:           result = {31'b0, $signed(op1) < $signed(op2)};
      // Upper immediate forms
      UOP_LUI:           result = op2;
      UOP_AUIPC:         result = pc + op2;
      default:           result = '0;
    endcase
  end

  // Valid bits carry reset, payload just follows
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val  <= 1'b0;
      cmp_val <= 1'b0;
    end else begin
      s1_val  <= issue_val;
      cmp_val <= s1_val;
    end
  end

  // Stage one captures at the issue edge
  always_ff @(posedge clk) begin
    if (issue_val) begin
      s1_result <= result;
      s1_waddr  <= waddr;
      s1_wen    <= wen;
      s1_seq    <= seq_num;
    end
  end

  // Stage two presents the completion
  always_ff @(posedge clk) begin
    if (s1_val) begin
      cmp_wdata   <= s1_result;
      cmp_waddr   <= s1_waddr;
      cmp_wen     <= s1_wen;
      cmp_seq_num <= s1_seq;
    end
  end

endmodule

/* rtl/decode_issue_unit.sv */
// ----------------------------------------------------------
// Decode and issue unit
// Holds one instruction, interlocks on pending sources and
// issues it to the ALU or multiply pipe
// ----------------------------------------------------------
`timescale 1ns/10ps

module decode_issue_unit import isa_pkg::*; import issue_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  // Fetch side
  input  logic                     inst_val,
  input  logic [31:0]              inst,
  input  logic [31:0]              pc,
  input  logic [SEQ_BITS-1:0]      seq_num,
  output logic                     inst_rdy,
  // Issue side, shared by both pipes
  output logic [NUM_PIPES-1:0]     issue_val,
  output uop_e                     uop,
  output logic [31:0]              op1,
  output logic [31:0]              op2,
  output logic [31:0]              issue_pc,
  output logic [REG_ADDR_BITS-1:0] issue_waddr,
  output logic                     issue_wen,
  output logic [SEQ_BITS-1:0]      issue_seq_num,
  // Completions
  input  logic                     alu_cmp_val,
  input  logic                     alu_cmp_wen,
  input  logic [REG_ADDR_BITS-1:0] alu_cmp_waddr,
  input  logic [31:0]              alu_cmp_wdata,
  input  logic                     mul_cmp_val,
  input  logic                     mul_cmp_wen,
  input  logic [REG_ADDR_BITS-1:0] mul_cmp_waddr,
  input  logic [31:0]              mul_cmp_wdata
);

  logic                     d_val;
  logic [31:0]              d_inst;
  logic [31:0]              d_pc;
  logic [SEQ_BITS-1:0]      d_seq;
  logic                     fetch_xfer;
  logic                     issued;
  logic                     issue_ok;
  logic                     dec_val;
  logic [REG_ADDR_BITS-1:0] raddr0;
  logic [REG_ADDR_BITS-1:0] raddr1;
  logic                     op2_imm;
  logic [31:0]              imm;
  logic [31:0]              rdata0;
  logic [31:0]              rdata1;
  logic                     pend0;
  logic                     pend1;

  // --------------------------------------------------------
  // Decode register
  // --------------------------------------------------------

  // Accept when empty or when the held instruction leaves now
  assign inst_rdy   = !d_val || issued;
  assign fetch_xfer = inst_val && inst_rdy;

  always_ff @(posedge clk) begin
    if (rst)
      d_val <= 1'b0;
    else if (fetch_xfer)
      d_val <= 1'b1;
    else if (issued)
      d_val <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (fetch_xfer) begin
      d_inst <= inst;
      d_pc   <= pc;
      d_seq  <= seq_num;
    end
  end

  // --------------------------------------------------------
  // Decode, operand read and routing
  // --------------------------------------------------------

  inst_decoder decoder_i (
    .inst    (d_inst),
    .dec_val (dec_val),
    .uop     (uop),
    .raddr0  (raddr0),
    .raddr1  (raddr1),
    .waddr   (issue_waddr),
    .wen     (issue_wen),
    .op2_imm (op2_imm),
    .imm     (imm)
  );

  regfile_pending regfile_i (
    .clk      (clk),
    .rst      (rst),
    .raddr0   (raddr0),
    .raddr1   (raddr1),
    .rdata0   (rdata0),
    .rdata1   (rdata1),
    .pend0    (pend0),
    .pend1    (pend1),
    .wen_a    (alu_cmp_val && alu_cmp_wen),
    .waddr_a  (alu_cmp_waddr),
    .wdata_a  (alu_cmp_wdata),
    .wen_b    (mul_cmp_val && mul_cmp_wen),
    .waddr_b  (mul_cmp_waddr),
    .wdata_b  (mul_cmp_wdata),
    .set_pend (issued && issue_wen),
    .set_addr (issue_waddr)
  );

  // Stall while either source waits on write-back
  assign issue_ok = d_val && dec_val && !pend0 && !pend1;

  inst_router router_i (
    .uop       (uop),
    .issue_ok  (issue_ok),
    .issue_val (issue_val),
    .issued    (issued)
  );

  // Operand select
  assign op1           = rdata0;
  assign op2           = op2_imm ? imm : rdata1;
  assign issue_pc      = d_pc;
  assign issue_seq_num = d_seq;

  // Fetch side holds a refused offer until it is taken
  assert property (@(posedge clk) disable iff (rst)
    inst_val && !inst_rdy |=>
      inst_val && $stable(inst) && $stable(pc) && $stable(seq_num));

endmodule

/* rtl/inst_router.sv */
// ----------------------------------------------------------
// Instruction router
// Picks the execution pipe for a micro-op
// ----------------------------------------------------------
`timescale 1ns/10ps

module inst_router import isa_pkg::*; import issue_pkg::*; (
  input  uop_e                 uop,
  input  logic                 issue_ok,
  output logic [NUM_PIPES-1:0] issue_val,
  output logic                 issued
);

  always_comb begin
    issue_val = '0;
    if (issue_ok) begin
      // Multiplies go to their own pipe, all else to the ALU
      if (uop == UOP_MUL)
        issue_val[PIPE_MUL] = 1'b1;
      else
        issue_val[PIPE_ALU] = 1'b1;
    end
  end

  assign issued = |issue_val;

endmodule

/* rtl/regfile_pending.sv */
// ----------------------------------------------------------
// Register file with pending bits
// 32 x 32, two read and two write ports, x0 tied to zero
// ----------------------------------------------------------
`timescale 1ns/10ps

module regfile_pending import issue_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [REG_ADDR_BITS-1:0] raddr0,
  input  logic [REG_ADDR_BITS-1:0] raddr1,
  output logic [31:0]              rdata0,
  output logic [31:0]              rdata1,
  output logic                     pend0,
  output logic                     pend1,
  input  logic                     wen_a,
  input  logic [REG_ADDR_BITS-1:0] waddr_a,
  input  logic [31:0]              wdata_a,
  input  logic                     wen_b,
  input  logic [REG_ADDR_BITS-1:0] waddr_b,
  input  logic [31:0]              wdata_b,
  input  logic                     set_pend,
  input  logic [REG_ADDR_BITS-1:0] set_addr
);

  logic [31:0]         regs [NUM_REGS];
  logic [NUM_REGS-1:0] pending;

  // Combinational reads, no bypass of same-cycle writes
  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];
  assign pend0  = pending[raddr0];
  assign pend1  = pending[raddr1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      pending <= '0;
    end else begin
      // Write-back clears the pending flag
      if (wen_a && waddr_a != '0) begin
        regs[waddr_a]    <= wdata_a;
        pending[waddr_a] <= 1'b0;
      end
      if (wen_b && waddr_b != '0) begin
        regs[waddr_b]    <= wdata_b;
        pending[waddr_b] <= 1'b0;
      end
      // Issue of a new producer wins over a same-edge clear
      if (set_pend && set_addr != '0) begin
        pending[set_addr] <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------
  // Checks
  // --------------------------------------------------------

  // Every completion retires a register marked at issue
  assert property (@(posedge clk) disable iff (rst)
    wen_a && waddr_a != '0 |-> pending[waddr_a]);
  assert property (@(posedge clk) disable iff (rst)
    wen_b && waddr_b != '0 |-> pending[waddr_b]);

  // Equal pipe latency keeps write-back to one port per cycle
  assert property (@(posedge clk) disable iff (rst) !(wen_a && wen_b));

endmodule

/* rtl/inst_decoder.sv */
// ----------------------------------------------------------
// Instruction decoder
// Maps one RV32 word onto a micro-op, register addresses
// and an immediate; flags words outside the subset
// ----------------------------------------------------------
`timescale 1ns/10ps

module inst_decoder import isa_pkg::*; import issue_pkg::*; (
  input  logic [31:0]              inst,
  output logic                     dec_val,
  output uop_e                     uop,
  output logic [REG_ADDR_BITS-1:0] raddr0,
  output logic [REG_ADDR_BITS-1:0] raddr1,
  output logic [REG_ADDR_BITS-1:0] waddr,
  output logic                     wen,
  output logic                     op2_imm,
  output logic [31:0]              imm
);

  // Instruction fields
  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [REG_ADDR_BITS-1:0] rs1;
  logic [REG_ADDR_BITS-1:0] rs2;
  imm_kind_e                imm_kind;

  assign opcode = inst[6:0];
  assign waddr  = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  always_comb begin
    uop      = UOP_INV;
    raddr0   = rs1;
    raddr1   = rs2;
    op2_imm  = 1'b0;
    imm_kind = IMM_I;
    case (opcode)
      OPC_OP: begin
        if (funct7 == FUNCT7_MULDIV && funct3 == FUNCT3_MUL)
          uop = UOP_MUL;
        else if (funct7 == FUNCT7_ALT && funct3 == FUNCT3_ADD)
          uop = UOP_SUB;
        else if (funct7 == FUNCT7_BASE) begin
          case (funct3)
            FUNCT3_ADD: uop = UOP_ADD;
            FUNCT3_SLT: uop = UOP_SLT;
            FUNCT3_XOR: uop = UOP_XOR;
            FUNCT3_OR:  uop = UOP_OR;
            FUNCT3_AND: uop = UOP_AND;
            default:    uop = UOP_INV;
          endcase
        end
      end
      OPC_OP_IMM: begin
        // rs2 field is immediate, so read x0 to avoid false stalls
        raddr1  = '0;
        op2_imm = 1'b1;
        case (funct3)
          FUNCT3_ADD: uop = UOP_ADDI;
          FUNCT3_XOR: uop = UOP_XORI;
          FUNCT3_OR:  uop = UOP_ORI;
          FUNCT3_AND: uop = UOP_ANDI;
          default:    uop = UOP_INV;
        endcase
      end
      OPC_LUI, OPC_AUIPC: begin
        // No register sources; auipc takes pc inside the ALU
        uop      = (opcode == OPC_LUI) ? UOP_LUI : UOP_AUIPC;
        raddr0   = '0;
        raddr1   = '0;
        op2_imm  = 1'b1;
        imm_kind = IMM_U;
      end
      default: uop = UOP_INV;
    endcase
  end

  // Every supported instruction writes rd
  assign dec_val = (uop != UOP_INV);
  assign wen     = dec_val;

  // Immediate generation
  assign imm = (imm_kind == IMM_U) ? {inst[31:12], 12'b0}
                                   : {{20{inst[31]}}, inst[31:20]};

endmodule

/* rtl/issue_pkg.sv */
// ----------------------------------------------------------
// Decode-issue subsystem sizing
// Sequence numbers, register file and pipe indices
// ----------------------------------------------------------
package issue_pkg;

  // Sequence number carried from fetch to completion
  localparam int SEQ_BITS = 8;

  // Architectural register file
  localparam int NUM_REGS      = 32;
  localparam int REG_ADDR_BITS = 5;

  // Execution pipes behind the issue stage
  localparam int NUM_PIPES = 2;
  localparam int PIPE_ALU  = 0;
  localparam int PIPE_MUL  = 1;

endpackage

/* rtl/isa_pkg.sv */
// ----------------------------------------------------------
// RV32 arithmetic subset definitions
// Opcodes, funct fields, micro-ops and immediate kinds
// ----------------------------------------------------------
package isa_pkg;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // funct7 variants of the OP opcode
  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // funct3 codes, shared by OP and OP-IMM
  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_SLT = 3'b010;
  localparam logic [2:0] FUNCT3_XOR = 3'b100;
  localparam logic [2:0] FUNCT3_OR  = 3'b110;
  localparam logic [2:0] FUNCT3_AND = 3'b111;
  // mul sits under FUNCT7_MULDIV
  localparam logic [2:0] FUNCT3_MUL = 3'b000;

  // One micro-op per supported instruction
  typedef enum logic [3:0] {
    UOP_ADD,  UOP_SUB,  UOP_AND,  UOP_OR,
    UOP_XOR,  UOP_SLT,  UOP_ADDI, UOP_ANDI,
    UOP_ORI,  UOP_XORI, UOP_LUI,  UOP_AUIPC,
    UOP_MUL,  UOP_INV
  } uop_e;

  // Immediate formats in use
  typedef enum logic {
    IMM_I,
    IMM_U
  } imm_kind_e;

endpackage
